/* rtl/l2_pkg.sv */
package l2_pkg;

    localparam int INDEX_W  = 2;
    localparam int OFFSET_W = 3;
    localparam int WAYS     = 4;
    localparam int SETS     = 4;
    localparam int LINE_W   = 256;
    localparam int HALF_W   = 128;
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W - 2;

    typedef logic [LINE_W-1:0]        line_t;
    typedef logic [HALF_W-1:0]        half_t;
    typedef logic [WAYS-1:0]          way_mask_t;
    typedef logic [$clog2(WAYS)-1:0]  way_idx_t;

    // same encoding as the L1 side uses
    typedef enum logic [1:0] {
        SRC_NONE   = 2'd0,
        SRC_ICACHE = 2'd1,
        SRC_DREAD  = 2'd2,
        SRC_DWRITE = 2'd3
    } src_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        src_t        src;
    } l1_req_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    function automatic logic [TAG_W-1:0] addr_tag(input logic [31:0] addr);
        return addr[31 -: TAG_W];
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(input logic [31:0] addr);
        return addr[OFFSET_W+2 +: INDEX_W];
    endfunction

    // word within the line
    function automatic logic [OFFSET_W-1:0] addr_offset(input logic [31:0] addr);
        return addr[2 +: OFFSET_W];
    endfunction

endpackage

/* rtl/l2_req_arb.sv */
`timescale 1ns/1ps

module l2_req_arb (
    input  logic            clk,
    input  logic            rst,
    input  logic            icache_req,
    input  logic [31:0]     icache_addr,
    input  logic            dcache_req,
    input  logic            dcache_wr,
    input  logic [31:0]     dcache_addr,
    input  logic [31:0]     dcache_wdata,
    input  logic [3:0]      dcache_wstrb,
    input  logic            accept,
    output l2_pkg::l1_req_t rbuf,
    output logic            icache_addr_ok,
    output logic            dcache_addr_ok
);

    l2_pkg::l1_req_t req;

    // dcache wins when both sides ask
    always_comb begin
        req.addr  = dcache_req ? dcache_addr : icache_addr;
        req.wdata = dcache_wdata;
        req.wstrb = dcache_wstrb;
        if (dcache_req) begin
            req.src = dcache_wr ? l2_pkg::SRC_DWRITE : l2_pkg::SRC_DREAD;
        end else if (icache_req) begin
            req.src = l2_pkg::SRC_ICACHE;
        end else begin
            req.src = l2_pkg::SRC_NONE;
        end
    end

    assign dcache_addr_ok = accept && dcache_req;
    assign icache_addr_ok = accept && icache_req && !dcache_req;

    always_ff @(posedge clk) begin
        if (rst) begin
            rbuf.src <= l2_pkg::SRC_NONE;
        end else if (accept && req.src != l2_pkg::SRC_NONE) begin
            rbuf <= req;
        end
    end

endmodule

/* rtl/l2_way_array.sv */
`timescale 1ns/1ps

module l2_way_array #(
    parameter type entry_t = logic
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [l2_pkg::INDEX_W-1:0] rd_index,
    output entry_t                     rd_entries [l2_pkg::WAYS],
    input  logic [l2_pkg::INDEX_W-1:0] wr_index,
    input  l2_pkg::way_mask_t          wr_mask,
    input  entry_t                     wr_entry
);

    entry_t store [l2_pkg::SETS][l2_pkg::WAYS];

    always_comb begin
        for (int w = 0; w < l2_pkg::WAYS; w++) begin
            rd_entries[w] = store[rd_index][w];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < l2_pkg::SETS; s++) begin
                for (int w = 0; w < l2_pkg::WAYS; w++) begin
                    store[s][w] <= '0;
                end
            end
        end else begin
            for (int w = 0; w < l2_pkg::WAYS; w++) begin
                if (wr_mask[w]) begin
                    store[wr_index][w] <= wr_entry;
                end
            end
        end
    end

endmodule

/* rtl/l2_plru.sv */
`timescale 1ns/1ps

module l2_plru (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [l2_pkg::INDEX_W-1:0] index,
    input  l2_pkg::src_t               src,
    input  l2_pkg::way_mask_t          valid,
    input  logic                       touch,
    input  l2_pkg::way_idx_t           touch_way,
    output l2_pkg::way_idx_t           victim
);

    // set means the upper way of the pair goes next
    logic [l2_pkg::SETS-1:0] lru_i;
    logic [l2_pkg::SETS-1:0] lru_d;
    logic                    side_d;
    logic                    pick_hi;
    l2_pkg::way_idx_t        lo_way;
    l2_pkg::way_idx_t        hi_way;

    assign side_d  = (src == l2_pkg::SRC_DREAD) || (src == l2_pkg::SRC_DWRITE);
    assign lo_way  = {side_d, 1'b0};
    assign hi_way  = {side_d, 1'b1};
    assign pick_hi = side_d ? lru_d[index] : lru_i[index];

    // empty ways fill first
    always_comb begin
        if (!valid[lo_way]) begin
            victim = lo_way;
        end else if (!valid[hi_way]) begin
            victim = hi_way;
        end else begin
            victim = pick_hi ? hi_way : lo_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_i <= '0;
            lru_d <= '0;
        end else if (touch) begin
            if (touch_way[1]) begin
                lru_d[index] <= ~touch_way[0];
            end else begin
                lru_i[index] <= ~touch_way[0];
            end
        end
    end

endmodule

/* rtl/l2_ctrl.sv */
`timescale 1ns/1ps

module l2_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  l2_pkg::l1_req_t    rbuf,
    input  logic               req_pending,
    output logic               accept,
    input  l2_pkg::tag_entry_t tags [l2_pkg::WAYS],
    input  l2_pkg::line_t      lines [l2_pkg::WAYS],
    output l2_pkg::way_mask_t  tag_mask,
    output l2_pkg::tag_entry_t tag_wr,
    output l2_pkg::way_mask_t  data_mask,
    output l2_pkg::line_t      data_wr,
    input  l2_pkg::way_idx_t   victim,
    output logic               plru_touch,
    output l2_pkg::way_idx_t   plru_way,
    input  l2_pkg::line_t      mem_rline,
    input  logic               mem_addr_ok_r,
    input  logic               mem_addr_ok_w,
    input  logic               mem_data_ok,
    output logic               mem_req_r,
    output logic               mem_req_w,
    output logic [31:0]        mem_addr_r,
    output logic [31:0]        mem_addr_w,
    output l2_pkg::line_t      mem_wline,
    output l2_pkg::half_t      resp_half,
    output logic               icache_data_ok,
    output logic               dcache_data_ok
);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WB_REQ, WB_WAIT, RF_REQ, RF_WAIT, FILL, RESP
    } state_t;

    state_t                      state;
    state_t                      state_nx;
    logic [l2_pkg::TAG_W-1:0]    req_tag;
    logic [l2_pkg::INDEX_W-1:0]  req_index;
    logic [l2_pkg::OFFSET_W-1:0] req_offset;
    logic                        is_store;
    l2_pkg::way_mask_t           hit_mask;
    logic                        hit;
    l2_pkg::way_idx_t            hit_way;
    l2_pkg::way_idx_t            way_r;
    l2_pkg::line_t               fill_line;
    l2_pkg::line_t               merged_fill;
    l2_pkg::line_t               hit_store;
    l2_pkg::line_t               resp_line;
    logic                        resp;

    // byte-strobed store into one word of a line
    function automatic l2_pkg::line_t merge_word(
        input l2_pkg::line_t               line,
        input logic [l2_pkg::OFFSET_W-1:0] offset,
        input logic [31:0]                 wdata,
        input logic [3:0]                  wstrb
    );
        l2_pkg::line_t res;
        res = line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[offset*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return res;
    endfunction

    assign req_tag    = l2_pkg::addr_tag(rbuf.addr);
    assign req_index  = l2_pkg::addr_index(rbuf.addr);
    assign req_offset = l2_pkg::addr_offset(rbuf.addr);
    assign is_store   = (rbuf.src == l2_pkg::SRC_DWRITE);

    // lookup hits in any way
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < l2_pkg::WAYS; w++) begin
            hit_mask[w] = tags[w].valid && (tags[w].tag == req_tag);
            if (hit_mask[w]) begin
                hit_way = l2_pkg::way_idx_t'(w);
            end
        end
    end
    assign hit = |hit_mask;

    assign hit_store   = merge_word(lines[hit_way], req_offset, rbuf.wdata, rbuf.wstrb);
    assign merged_fill = is_store ? merge_word(fill_line, req_offset, rbuf.wdata, rbuf.wstrb)
                                  : fill_line;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (req_pending) state_nx = LOOKUP;
            LOOKUP: begin
                if (hit) begin
                    state_nx = RESP;
                end else if (tags[victim].valid && tags[victim].dirty) begin
                    state_nx = WB_REQ;
                end else begin
                    state_nx = RF_REQ;
                end
            end
            WB_REQ:  if (mem_addr_ok_w) state_nx = WB_WAIT;
            WB_WAIT: if (mem_data_ok) state_nx = RF_REQ;
            RF_REQ:  if (mem_addr_ok_r) state_nx = RF_WAIT;
            RF_WAIT: if (mem_data_ok) state_nx = FILL;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nx;
        end
    end

    always_ff @(posedge clk) begin
        if (state == LOOKUP) begin
            way_r <= hit ? hit_way : victim;
        end
        if (state == RF_WAIT && mem_data_ok) begin
            fill_line <= mem_rline;
        end
    end

    // store hit marks dirty, fill installs the new tag
    always_comb begin
        tag_mask  = '0;
        data_mask = '0;
        tag_wr    = '{valid: 1'b1, dirty: is_store, tag: req_tag};
        data_wr   = merged_fill;
        if (state == LOOKUP && hit && is_store) begin
            tag_mask  = l2_pkg::way_mask_t'(1) << hit_way;
            data_mask = l2_pkg::way_mask_t'(1) << hit_way;
            data_wr   = hit_store;
        end else if (state == FILL) begin
            tag_mask  = l2_pkg::way_mask_t'(1) << way_r;
            data_mask = l2_pkg::way_mask_t'(1) << way_r;
        end
    end

    assign plru_touch = (state == LOOKUP && hit) || (state == FILL);
    assign plru_way   = (state == FILL) ? way_r : hit_way;

    assign accept     = (state == IDLE);
    assign mem_req_w  = (state == WB_REQ);
    assign mem_req_r  = (state == RF_REQ);
    assign mem_addr_w = {tags[way_r].tag, req_index, {(l2_pkg::OFFSET_W + 2){1'b0}}};
    assign mem_addr_r = {req_tag, req_index, {(l2_pkg::OFFSET_W + 2){1'b0}}};
    assign mem_wline  = lines[way_r];

    // upper offset bit picks the half
    assign resp_line = (state == FILL) ? merged_fill : lines[way_r];
    assign resp_half = req_offset[l2_pkg::OFFSET_W-1] ? resp_line[l2_pkg::LINE_W-1:l2_pkg::HALF_W]
                                                      : resp_line[l2_pkg::HALF_W-1:0];

    assign resp           = (state == RESP) || (state == FILL);
    assign icache_data_ok = resp && (rbuf.src == l2_pkg::SRC_ICACHE);
    assign dcache_data_ok = resp && (rbuf.src == l2_pkg::SRC_DREAD ||
                                     rbuf.src == l2_pkg::SRC_DWRITE);

endmodule

/* rtl/l2_cache.sv */
`timescale 1ns/1ps

module l2_cache (
    input  logic          clk,
    input  logic          rst,
    // icache side
    input  logic          icache_req,
    input  logic [31:0]   icache_addr,
    output logic          icache_addr_ok,
    output logic          icache_data_ok,
    output l2_pkg::half_t icache_dout,
    // dcache side
    input  logic          dcache_req,
    input  logic          dcache_wr,
    input  logic [31:0]   dcache_addr,
    input  logic [31:0]   dcache_wdata,
    input  logic [3:0]    dcache_wstrb,
    output logic          dcache_addr_ok,
    output logic          dcache_data_ok,
    output l2_pkg::half_t dcache_dout,
    // memory bridge
    output logic          mem_req_r,
    output logic [31:0]   mem_addr_r,
    input  logic          mem_addr_ok_r,
    output logic          mem_req_w,
    output logic [31:0]   mem_addr_w,
    output l2_pkg::line_t mem_wline,
    input  logic          mem_addr_ok_w,
    input  l2_pkg::line_t mem_rline,
    input  logic          mem_data_ok
);

    l2_pkg::l1_req_t            rbuf;
    logic                       accept;
    logic [l2_pkg::INDEX_W-1:0] rbuf_index;
    l2_pkg::tag_entry_t         tags [l2_pkg::WAYS];
    l2_pkg::line_t              lines [l2_pkg::WAYS];
    l2_pkg::way_mask_t          tag_mask;
    l2_pkg::way_mask_t          data_mask;
    l2_pkg::tag_entry_t         tag_wr;
    l2_pkg::line_t              data_wr;
    l2_pkg::way_mask_t          tag_valid;
    l2_pkg::way_idx_t           victim;
    l2_pkg::way_idx_t           plru_way;
    logic                       plru_touch;
    l2_pkg::half_t              resp_half;

    assign rbuf_index  = l2_pkg::addr_index(rbuf.addr);
    assign icache_dout = resp_half;
    assign dcache_dout = resp_half;

    for (genvar w = 0; w < l2_pkg::WAYS; w++) begin : g_valid
        assign tag_valid[w] = tags[w].valid;
    end

    l2_req_arb i_req_arb (
        .clk            (clk),
        .rst            (rst),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_wstrb   (dcache_wstrb),
        .accept         (accept),
        .rbuf           (rbuf),
        .icache_addr_ok (icache_addr_ok),
        .dcache_addr_ok (dcache_addr_ok)
    );

    l2_way_array #(.entry_t(l2_pkg::tag_entry_t)) i_tag_array (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (rbuf_index),
        .rd_entries (tags),
        .wr_index   (rbuf_index),
        .wr_mask    (tag_mask),
        .wr_entry   (tag_wr)
    );

    l2_way_array #(.entry_t(l2_pkg::line_t)) i_data_array (
        .clk        (clk),
        .rst        (rst),
        .rd_index   (rbuf_index),
        .rd_entries (lines),
        .wr_index   (rbuf_index),
        .wr_mask    (data_mask),
        .wr_entry   (data_wr)
    );

    l2_plru i_plru (
        .clk       (clk),
        .rst       (rst),
        .index     (rbuf_index),
        .src       (rbuf.src),
        .valid     (tag_valid),
        .touch     (plru_touch),
        .touch_way (plru_way),
        .victim    (victim)
    );

    l2_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .rbuf           (rbuf),
        .req_pending    (icache_req || dcache_req),
        .accept         (accept),
        .tags           (tags),
        .lines          (lines),
        .tag_mask       (tag_mask),
        .tag_wr         (tag_wr),
        .data_mask      (data_mask),
        .data_wr        (data_wr),
        .victim         (victim),
        .plru_touch     (plru_touch),
        .plru_way       (plru_way),
        .mem_rline      (mem_rline),
        .mem_addr_ok_r  (mem_addr_ok_r),
        .mem_addr_ok_w  (mem_addr_ok_w),
        .mem_data_ok    (mem_data_ok),
        .mem_req_r      (mem_req_r),
        .mem_req_w      (mem_req_w),
        .mem_addr_r     (mem_addr_r),
        .mem_addr_w     (mem_addr_w),
        .mem_wline      (mem_wline),
        .resp_half      (resp_half),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok)
    );

endmodule

/* bench/l2_mem_model.sv */
`timescale 1ns/1ps

module l2_mem_model (
    input  logic          clk,
    input  logic          rst,
    input  logic          mem_req_r,
    input  logic [31:0]   mem_addr_r,
    output logic          mem_addr_ok_r,
    input  logic          mem_req_w,
    input  logic [31:0]   mem_addr_w,
    input  l2_pkg::line_t mem_wline,
    output logic          mem_addr_ok_w,
    output l2_pkg::line_t mem_rline,
    output logic          mem_data_ok,
    output int            read_count,
    output int            write_count,
    output logic [31:0]   last_wr_addr,
    output l2_pkg::line_t last_wr_line
);

    localparam logic [31:0] FILL_KEY = 32'h694a_8de9;

    logic [31:0] words [logic [31:0]];
    logic [31:0] rd_addr;
    logic        busy;
    int          wait_cnt;
    int          seed = 32'h694a_8de9;

    // untouched words read back as address xor key
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (words.exists(addr)) begin
            return words[addr];
        end
        return addr ^ FILL_KEY;
    endfunction

    initial begin
        mem_addr_ok_r = 1'b0;
        mem_addr_ok_w = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rline     = '0;
        busy          = 1'b0;
        read_count    = 0;
        write_count   = 0;
        last_wr_addr  = '0;
        last_wr_line  = '0;
    end

    always @(posedge clk) begin
        mem_addr_ok_r <= 1'b0;
        mem_addr_ok_w <= 1'b0;
        mem_data_ok   <= 1'b0;
        if (rst) begin
            busy        <= 1'b0;
            read_count  <= 0;
            write_count <= 0;
        end else if (!busy) begin
            // a write-back wins if both were ever raised
            if (mem_req_w) begin
                for (int i = 0; i < 8; i++) begin
                    words[mem_addr_w + 32'(i * 4)] = mem_wline[i*32 +: 32];
                end
                last_wr_addr  <= mem_addr_w;
                last_wr_line  <= mem_wline;
                write_count   <= write_count + 1;
                mem_addr_ok_w <= 1'b1;
                busy          <= 1'b1;
                wait_cnt      <= 32'd1 + ($unsigned($random(seed)) % 32'd4);
            end else if (mem_req_r) begin
                rd_addr       <= mem_addr_r;
                read_count    <= read_count + 1;
                mem_addr_ok_r <= 1'b1;
                busy          <= 1'b1;
                wait_cnt      <= 32'd1 + ($unsigned($random(seed)) % 32'd4);
            end
        end else if (wait_cnt > 1) begin
            wait_cnt <= wait_cnt - 1;
        end else begin
            for (int i = 0; i < 8; i++) begin
                mem_rline[i*32 +: 32] <= word_at(rd_addr + 32'(i * 4));
            end
            mem_data_ok <= 1'b1;
            busy        <= 1'b0;
        end
    end

endmodule

/* bench/l2_cache_assert.sv */
`timescale 1ns/1ps

module l2_cache_assert (
    input logic clk,
    input logic rst,
    input logic icache_addr_ok,
    input logic dcache_addr_ok,
    input logic icache_data_ok,
    input logic dcache_data_ok,
    input logic mem_req_r,
    input logic mem_req_w
);

    int   fail_count = 0;
    logic i_open;
    logic d_open;

    // set from a side's addrOK until its dataOK
    always_ff @(posedge clk) begin
        if (rst) begin
            i_open <= 1'b0;
            d_open <= 1'b0;
        end else begin
            if (icache_addr_ok) begin
                i_open <= 1'b1;
            end else if (icache_data_ok) begin
                i_open <= 1'b0;
            end
            if (dcache_addr_ok) begin
                d_open <= 1'b1;
            end else if (dcache_data_ok) begin
                d_open <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(icache_addr_ok && dcache_addr_ok))
        else begin
            fail_count++;
            $error("icache and dcache addrOK high in the same cycle");
        end

    assert property (@(posedge clk) disable iff (rst) !(mem_req_r && mem_req_w))
        else begin
            fail_count++;
            $error("memory read and write requests high together");
        end

    assert property (@(posedge clk) disable iff (rst) icache_data_ok |-> i_open)
        else begin
            fail_count++;
            $error("icache dataOK without a preceding addrOK");
        end

    assert property (@(posedge clk) disable iff (rst) dcache_data_ok |-> d_open)
        else begin
            fail_count++;
            $error("dcache dataOK without a preceding addrOK");
        end

endmodule

/* bench/tb_l2_cache.sv */
`timescale 1ns/1ps

module tb_l2_cache;

    localparam logic [31:0] FILL_KEY = 32'h694a_8de9;
    localparam int          TIMEOUT  = 200;

    logic          clk = 1'b0;
    logic          rst;
    logic          icache_req;
    logic [31:0]   icache_addr;
    logic          icache_addr_ok;
    logic          icache_data_ok;
    l2_pkg::half_t icache_dout;
    logic          dcache_req;
    logic          dcache_wr;
    logic [31:0]   dcache_addr;
    logic [31:0]   dcache_wdata;
    logic [3:0]    dcache_wstrb;
    logic          dcache_addr_ok;
    logic          dcache_data_ok;
    l2_pkg::half_t dcache_dout;
    logic          mem_req_r;
    logic [31:0]   mem_addr_r;
    logic          mem_addr_ok_r;
    logic          mem_req_w;
    logic [31:0]   mem_addr_w;
    l2_pkg::line_t mem_wline;
    logic          mem_addr_ok_w;
    l2_pkg::line_t mem_rline;
    logic          mem_data_ok;
    int            read_count;
    int            write_count;
    logic [31:0]   last_wr_addr;
    l2_pkg::line_t last_wr_line;

    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] shadow [logic [31:0]];

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    l2_cache i_l2_cache (.*);

    l2_mem_model i_mem (.*);

    bind l2_cache l2_cache_assert i_assert (
        .clk            (clk),
        .rst            (rst),
        .icache_addr_ok (icache_addr_ok),
        .dcache_addr_ok (dcache_addr_ok),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok),
        .mem_req_r      (mem_req_r),
        .mem_req_w      (mem_req_w)
    );

    task automatic check_eq(input string name, input logic [255:0] got, input logic [255:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic abort_run(input string why, input logic [31:0] addr);
        errors++;
        $display("%0t: %s, address %h", $time, why, addr);
        $display("checks: %0d errors: %0d", checks, errors);
        $display("TB FAILED");
        $finish;
    endtask

    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ FILL_KEY;
    endfunction

    function automatic l2_pkg::half_t expect_half(input logic [31:0] addr);
        l2_pkg::half_t h;
        for (int i = 0; i < 4; i++) begin
            h[i*32 +: 32] = expect_word({addr[31:4], 4'b0} + 32'(i * 4));
        end
        return h;
    endfunction

    function automatic l2_pkg::line_t expect_line(input logic [31:0] addr);
        return {expect_half({addr[31:5], 5'h10}), expect_half({addr[31:5], 5'h00})};
    endfunction

    function automatic void store_bytes(
        input logic [31:0] addr,
        input logic [31:0] wdata,
        input logic [3:0]  wstrb
    );
        logic [31:0] w;
        w = expect_word({addr[31:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                w[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        shadow[{addr[31:2], 2'b00}] = w;
    endfunction

    // one L1 access, checked against the expected half-line
    task automatic access(
        input  logic          side_d,
        input  logic          wr,
        input  logic [31:0]   addr,
        input  logic [31:0]   wdata,
        input  logic [3:0]    wstrb,
        output l2_pkg::half_t rdata,
        output int            ok_at,
        output int            done_at
    );
        string name;
        int    n;
        @(posedge clk);
        #1;
        if (side_d) begin
            name         = "dcache_dout";
            dcache_req   = 1'b1;
            dcache_wr    = wr;
            dcache_addr  = addr;
            dcache_wdata = wdata;
            dcache_wstrb = wstrb;
            if (wr) begin
                store_bytes(addr, wdata, wstrb);
            end
        end else begin
            name        = "icache_dout";
            icache_req  = 1'b1;
            icache_addr = addr;
        end
        n = 0;
        @(posedge clk);
        while (!(side_d ? dcache_addr_ok : icache_addr_ok)) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("request never got addrOK", addr);
            end
            @(posedge clk);
        end
        ok_at = cycle;
        #1;
        if (side_d) begin
            dcache_req = 1'b0;
        end else begin
            icache_req = 1'b0;
        end
        n = 0;
        @(posedge clk);
        while (!(side_d ? dcache_data_ok : icache_data_ok)) begin
            n++;
            if (n > TIMEOUT) begin
                abort_run("accepted request never got dataOK", addr);
            end
            @(posedge clk);
        end
        done_at = cycle;
        rdata   = side_d ? dcache_dout : icache_dout;
        check_eq(name, 256'(rdata), 256'(expect_half(addr)));
    endtask

    task automatic read_miss_then_hit();
        l2_pkg::half_t h;
        int            ok_at;
        int            done_at;
        int            rd_before;
        rd_before = read_count;
        access(1'b1, 1'b0, 32'h0000_1004, '0, '0, h, ok_at, done_at);
        check_eq("read_count", 256'(read_count), 256'(rd_before + 1));
        access(1'b1, 1'b0, 32'h0000_1014, '0, '0, h, ok_at, done_at);
        check_eq("read_count", 256'(read_count), 256'(rd_before + 1));
        check_eq("hit latency", 256'(done_at - ok_at), 256'(2));
    endtask

    task automatic store_merge();
        l2_pkg::half_t h;
        int            ok_at;
        int            done_at;
        access(1'b1, 1'b1, 32'h0000_1008, 32'ha5c3_5a3c, 4'b0101, h, ok_at, done_at);
        access(1'b1, 1'b0, 32'h0000_1008, '0, '0, h, ok_at, done_at);
        // bytes 0 and 2 come from the store
        check_eq("dcache_dout word 2", 256'(h[64 +: 32]),
                 256'(((32'h0000_1008 ^ FILL_KEY) & 32'hff00_ff00) | 32'h00c3_003c));
    endtask

    task automatic dirty_eviction();
        l2_pkg::half_t h;
        int            ok_at;
        int            done_at;
        int            wr_before;
        int            rd_before;
        wr_before = write_count;
        access(1'b1, 1'b1, 32'h0000_2020, 32'h1234_5678, 4'b0011, h, ok_at, done_at);
        access(1'b1, 1'b1, 32'h0000_3024, 32'h9abc_def0, 4'b1111, h, ok_at, done_at);
        check_eq("write_count", 256'(write_count), 256'(wr_before));
        access(1'b1, 1'b1, 32'h0000_4028, 32'h0f0f_0f0f, 4'b1100, h, ok_at, done_at);
        check_eq("write_count", 256'(write_count), 256'(wr_before + 1));
        check_eq("mem_addr_w", 256'(last_wr_addr), 256'(32'h0000_2020));
        check_eq("mem_wline", 256'(last_wr_line), 256'(expect_line(32'h0000_2020)));
        rd_before = read_count;
        access(1'b1, 1'b0, 32'h0000_2020, '0, '0, h, ok_at, done_at);
        check_eq("read_count", 256'(read_count), 256'(rd_before + 1));
        check_eq("dcache_dout word 0", 256'(h[31:0]),
                 256'(((32'h0000_2020 ^ FILL_KEY) & 32'hffff_0000) | 32'h0000_5678));
    endtask

    task automatic way_partition();
        l2_pkg::half_t h;
        int            ok_at;
        int            done_at;
        int            rd_before;
        access(1'b0, 1'b0, 32'h0000_5040, '0, '0, h, ok_at, done_at);
        access(1'b0, 1'b0, 32'h0000_6040, '0, '0, h, ok_at, done_at);
        access(1'b1, 1'b0, 32'h0000_7040, '0, '0, h, ok_at, done_at);
        access(1'b1, 1'b0, 32'h0000_8040, '0, '0, h, ok_at, done_at);
        access(1'b1, 1'b0, 32'h0000_9040, '0, '0, h, ok_at, done_at);
        rd_before = read_count;
        access(1'b0, 1'b0, 32'h0000_5044, '0, '0, h, ok_at, done_at);
        access(1'b0, 1'b0, 32'h0000_6050, '0, '0, h, ok_at, done_at);
        check_eq("read_count", 256'(read_count), 256'(rd_before));
    endtask

    task automatic d_over_i_priority();
        l2_pkg::half_t d_half;
        l2_pkg::half_t i_half;
        int            d_ok;
        int            d_done;
        int            i_ok;
        int            i_done;
        fork
            access(1'b1, 1'b0, 32'h0000_b060, '0, '0, d_half, d_ok, d_done);
            access(1'b0, 1'b0, 32'h0000_a070, '0, '0, i_half, i_ok, i_done);
        join
        check_eq("dcache addrOK before icache", 256'(d_ok < i_ok), 256'(1));
    endtask

    initial begin
        rst          = 1'b1;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        read_miss_then_hit();
        store_merge();
        dirty_eviction();
        way_partition();
        d_over_i_priority();
        repeat (4) @(posedge clk);
        errors += i_l2_cache.i_assert.fail_count;
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/l2_pkg.sv
rtl/l2_req_arb.sv
rtl/l2_way_array.sv
rtl/l2_plru.sv
rtl/l2_ctrl.sv
rtl/l2_cache.sv
bench/l2_mem_model.sv
bench/l2_cache_assert.sv
bench/tb_l2_cache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_l2_cache -f vlog.f \
    && ./obj_dir/Vtb_l2_cache +verilator+error+limit+100 | tee /dev/stderr \
        | grep -q "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
